// ==== common/cpuPkg.sv ====
`default_nettype none

package cpuPkg;

    //////////////////////////////////////////////////
    // Opcodes and instruction classes
    //////////////////////////////////////////////////

    // Coded as the ARM opcode field Instr[24:21]
    typedef enum logic [3:0] {
        OpAnd = 4'h0,
        OpEor = 4'h1,
        OpSub = 4'h2,
        OpRsb = 4'h3,
        OpAdd = 4'h4,
        OpAdc = 4'h5,
        OpSbc = 4'h6,
        OpRsc = 4'h7,
        OpTst = 4'h8,
        OpTeq = 4'h9,
        OpCmp = 4'hA,
        OpCmn = 4'hB,
        OpOrr = 4'hC,
        OpMov = 4'hD,
        OpBic = 4'hE,
        OpMvn = 4'hF
    } aluOp_e;

    // Instr[27:26]
    typedef enum logic [1:0] {
        ClsDp     = 2'b00,
        ClsMem    = 2'b01,
        ClsBranch = 2'b10
    } instrClass_e;

    //////////////////////////////////////////////////
    // Decoded control and flags
    //////////////////////////////////////////////////

    typedef struct packed {
        logic       regWrite;
        logic       memWrite;
        logic       memToReg;
        logic       aluSrc;     // 1 selects ExtImm
        logic       noWrite;    // Compare ops skip the Rd update
        logic       branch;
        logic       pcs;        // PC gets written
        logic [1:0] flagWrite;  // [1] NZ group, [0] CV group
        aluOp_e     aluControl;
    } ctrl_t;

    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } flags_t;

endpackage

`default_nettype wire

// ==== decode/instrDecoder.sv ====
`default_nettype none

module instrDecoder import cpuPkg::*; (
    input  logic [31:0] Instr,
    output ctrl_t       ctrl,
    output logic [31:0] ExtImm,
    output logic [3:0]  RA1,
    output logic [3:0]  RA2
);

    instrClass_e cls;
    logic [3:0]  rn;
    logic [3:0]  rd;
    logic [3:0]  rm;
    logic [3:0]  rot;
    logic [7:0]  imm8;
    logic        immOp;
    logic        sBit;
    logic        upBit;
    logic        loadBit;
    logic [63:0] rotImm;

    assign cls     = instrClass_e'(Instr[27:26]);
    assign immOp   = Instr[25];
    assign upBit   = Instr[23];
    assign sBit    = Instr[20];
    assign loadBit = Instr[20];
    assign rn      = Instr[19:16];
    assign rd      = Instr[15:12];
    assign rot     = Instr[11:8];
    assign imm8    = Instr[7:0];
    assign rm      = Instr[3:0];

    // Rotate right by twice the rot field
    assign rotImm = {24'b0, imm8, 24'b0, imm8} >> {rot, 1'b0};

    //////////////////////////////////////////////////
    // Main decode
    //////////////////////////////////////////////////

    always_comb begin
        ctrl            = '0;
        ctrl.aluControl = OpAdd;
        ExtImm          = {20'b0, Instr[11:0]};

        case (cls)
            ClsDp: begin
                ctrl.regWrite   = 1'b1;
                ctrl.aluSrc     = immOp;
                ctrl.aluControl = aluOp_e'(Instr[24:21]);
                ctrl.noWrite    = (Instr[24:23] == 2'b10); // TST TEQ CMP CMN
                if (sBit) begin
                    if (ctrl.aluControl inside {OpSub, OpRsb, OpAdd, OpAdc,
                                                OpSbc, OpRsc, OpCmp, OpCmn}) begin
                        ctrl.flagWrite = 2'b11;
                    end else begin
                        ctrl.flagWrite = 2'b10; // Logic ops touch NZ only
                    end
                end
                ExtImm = rotImm[31:0];
            end

            ClsMem: begin
                ctrl.aluSrc     = 1'b1;
                ctrl.aluControl = upBit ? OpAdd : OpSub;
                if (loadBit) begin
                    ctrl.regWrite = 1'b1;
                    ctrl.memToReg = 1'b1;
                end else begin
                    ctrl.memWrite = 1'b1;
                end
            end

            ClsBranch: begin
                ctrl.branch     = 1'b1;
                ctrl.aluSrc     = 1'b1;
                ctrl.aluControl = OpAdd;
                ExtImm          = {{6{Instr[23]}}, Instr[23:0], 2'b00};
            end

            default: begin
                // Coprocessor space decodes as a no-op
            end
        endcase

        ctrl.pcs = ctrl.branch | (ctrl.regWrite & ~ctrl.noWrite & (rd == 4'd15));
    end

    // Read port select
    assign RA1 = (cls == ClsBranch) ? 4'd15 : rn;
    assign RA2 = (cls == ClsMem && !loadBit) ? rd : rm; // Store data from Rd

endmodule

`default_nettype wire

// ==== decode/condUnit.sv ====
`default_nettype none

module condUnit import cpuPkg::*; (
    input  logic       CLK,
    input  logic       rst,
    input  logic [3:0] Cond,
    input  ctrl_t      ctrl,
    input  flags_t     aluFlags,
    output flags_t     nzcv,
    output logic       RegWriteEn,
    output logic       MemWrite,
    output logic       PCSrc
);

    logic condEx;

    // Condition field against stored flags
    always_comb begin
        case (Cond)
            4'h0: condEx = nzcv.z;                              // EQ
            4'h1: condEx = ~nzcv.z;                             // NE
            4'h2: condEx = nzcv.c;                              // CS
            4'h3: condEx = ~nzcv.c;                             // CC
            4'h4: condEx = nzcv.n;                              // MI
            4'h5: condEx = ~nzcv.n;                             // PL
            4'h6: condEx = nzcv.v;                              // VS
            4'h7: condEx = ~nzcv.v;                             // VC
            4'h8: condEx = nzcv.c & ~nzcv.z;                    // HI
            4'h9: condEx = ~nzcv.c | nzcv.z;                    // LS
            4'hA: condEx = (nzcv.n == nzcv.v);                  // GE
            4'hB: condEx = (nzcv.n != nzcv.v);                  // LT
            4'hC: condEx = ~nzcv.z & (nzcv.n == nzcv.v);        // GT
            4'hD: condEx = nzcv.z | (nzcv.n != nzcv.v);         // LE
            4'hE: condEx = 1'b1;                                // AL
            default: condEx = 1'b0;
        endcase
    end

    //////////////////////////////////////////////////
    // NZCV register
    //////////////////////////////////////////////////

    always_ff @(posedge CLK) begin
        if (rst) begin
            nzcv <= '0;
        end else if (condEx) begin
            if (ctrl.flagWrite[1]) begin
                nzcv.n <= aluFlags.n;
                nzcv.z <= aluFlags.z;
            end
            if (ctrl.flagWrite[0]) begin
                nzcv.c <= aluFlags.c;
                nzcv.v <= aluFlags.v;
            end
        end
    end

    assign RegWriteEn = condEx & ctrl.regWrite & ~ctrl.noWrite;
    assign MemWrite   = condEx & ctrl.memWrite;
    assign PCSrc      = condEx & ctrl.pcs;

endmodule

`default_nettype wire

// ==== design/alu.sv ====
`default_nettype none

module alu import cpuPkg::*; (
    input  logic [31:0] SrcA,
    input  logic [31:0] RdB,
    input  logic [31:0] ExtImm,
    input  ctrl_t       ctrl,
    input  logic        CarryIn,
    output logic [31:0] ALUResult,
    output flags_t      aluFlags
);

    logic [31:0] srcB;
    logic [31:0] addX;
    logic [31:0] addY;
    logic        addCin;
    logic [32:0] sum;
    logic        isArith;

    assign srcB = ctrl.aluSrc ? ExtImm : RdB;

    // Shared adder operands with subtraction as x + ~y + 1
    always_comb begin
        addX    = SrcA;
        addY    = srcB;
        addCin  = 1'b0;
        isArith = 1'b1;
        case (ctrl.aluControl)
            OpAdd, OpCmn: ;
            OpAdc:        addCin = CarryIn;
            OpSub, OpCmp: begin
                addY   = ~srcB;
                addCin = 1'b1;
            end
            OpSbc: begin
                addY   = ~srcB;
                addCin = CarryIn;
            end
            OpRsb: begin
                addX   = srcB;
                addY   = ~SrcA;
                addCin = 1'b1;
            end
            OpRsc: begin
                addX   = srcB;
                addY   = ~SrcA;
                addCin = CarryIn;
            end
            default: isArith = 1'b0;
        endcase
    end

    assign sum = {1'b0, addX} + {1'b0, addY} + {32'b0, addCin};

    always_comb begin
        case (ctrl.aluControl)
            OpAnd, OpTst: ALUResult = SrcA & srcB;
            OpEor, OpTeq: ALUResult = SrcA ^ srcB;
            OpOrr:        ALUResult = SrcA | srcB;
            OpMov:        ALUResult = srcB;
            OpBic:        ALUResult = SrcA & ~srcB;
            OpMvn:        ALUResult = ~srcB;
            default:      ALUResult = sum[31:0];
        endcase
    end

    assign aluFlags.n = ALUResult[31];
    assign aluFlags.z = (ALUResult == 32'd0);
    assign aluFlags.c = isArith ? sum[32] : CarryIn;
    assign aluFlags.v = isArith & (addX[31] == addY[31]) & (sum[31] != addX[31]);

endmodule

`default_nettype wire

// ==== design/regFile.sv ====
`default_nettype none

module regFile (
    input  logic        CLK,
    input  logic        rst,
    input  logic [3:0]  RA1,
    input  logic [3:0]  RA2,
    input  logic [3:0]  WA,
    input  logic        WriteEn,
    input  logic        MemToReg,
    input  logic [31:0] ALUResult,
    input  logic [31:0] ReadData,
    input  logic [31:0] PCPlus8,
    output logic [31:0] RdA,
    output logic [31:0] RdB
);

    logic [31:0] regs [0:14];  // R0 to R14
    logic [31:0] result;

    assign result = MemToReg ? ReadData : ALUResult;

    always_ff @(posedge CLK) begin
        if (rst) begin
            for (int i = 0; i < 15; i++) begin
                regs[i] <= '0;
            end
        end else if (WriteEn && WA != 4'd15) begin
            regs[WA] <= result;
        end
    end

    // R15 reads as PC+8
    assign RdA = (RA1 == 4'd15) ? PCPlus8 : regs[RA1];
    assign RdB = (RA2 == 4'd15) ? PCPlus8 : regs[RA2];

endmodule

`default_nettype wire

// ==== design/execCore.sv ====
`default_nettype none

module execCore import cpuPkg::*; (
    input  logic        CLK,
    input  logic        rst,
    input  logic [31:0] Instr,
    input  logic [31:0] PCPlus8,
    input  logic [31:0] ReadData,
    output logic        PCSrc,
    output logic        MemWrite,
    output logic [31:0] ALUResult,
    output logic [31:0] WriteData
);

    ctrl_t       ctrl;
    flags_t      aluFlags;
    flags_t      nzcv;
    logic [31:0] ExtImm;
    logic [31:0] RdA;
    logic [31:0] RdB;
    logic [3:0]  RA1;
    logic [3:0]  RA2;
    logic        RegWriteEn;

    //////////////////////////////////////////////////
    // Decode and condition
    //////////////////////////////////////////////////

    instrDecoder uDecoder (
        .Instr  (Instr),
        .ctrl   (ctrl),
        .ExtImm (ExtImm),
        .RA1    (RA1),
        .RA2    (RA2)
    );

    condUnit uCond (
        .CLK        (CLK),
        .rst        (rst),
        .Cond       (Instr[31:28]),
        .ctrl       (ctrl),
        .aluFlags   (aluFlags),
        .nzcv       (nzcv),
        .RegWriteEn (RegWriteEn),
        .MemWrite   (MemWrite),
        .PCSrc      (PCSrc)
    );

    //////////////////////////////////////////////////
    // Datapath
    //////////////////////////////////////////////////

    alu uAlu (
        .SrcA      (RdA),
        .RdB       (RdB),
        .ExtImm    (ExtImm),
        .ctrl      (ctrl),
        .CarryIn   (nzcv.c),
        .ALUResult (ALUResult),
        .aluFlags  (aluFlags)
    );

    regFile uRegs (
        .CLK       (CLK),
        .rst       (rst),
        .RA1       (RA1),
        .RA2       (RA2),
        .WA        (Instr[15:12]),  // Rd
        .WriteEn   (RegWriteEn),
        .MemToReg  (ctrl.memToReg),
        .ALUResult (ALUResult),
        .ReadData  (ReadData),
        .PCPlus8   (PCPlus8),
        .RdA       (RdA),
        .RdB       (RdB)
    );

    assign WriteData = RdB;  // Store data

endmodule

`default_nettype wire

// ==== dv/clockGen.sv ====
`default_nettype none

module clockGen (
    output logic clk,
    output logic rst
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // 100 ns period
    end

    // Held through the first 16 rising edges
    initial begin
        rst = 1'b1;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

// ==== dv/execCoreTb.sv ====
`default_nettype none

module execCoreTb import cpuPkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    // Reset cycles, all test steps and the final edge
    localparam int TestCycles = 255;
    localparam int MaxCycles  = 2 * TestCycles;

    logic        clk;
    logic        rst;
    logic [31:0] Instr;
    logic [31:0] PCPlus8;
    logic [31:0] ReadData;
    logic        PCSrc;
    logic        MemWrite;
    logic [31:0] ALUResult;
    logic [31:0] WriteData;

    logic [31:0] modelRegs [0:14];
    flags_t      modelFlags;
    logic [31:0] lfsrState = 32'he808;
    int          errors = 0;
    int          cycles = 0;
    aluOp_e      flagOps [0:7] = '{OpCmp, OpCmn, OpTst, OpTeq, OpSub, OpAdd, OpAdc, OpSbc};

    clockGen clocks (
        .clk (clk),
        .rst (rst)
    );

    execCore DUT (
        .CLK       (clk),
        .rst       (rst),
        .Instr     (Instr),
        .PCPlus8   (PCPlus8),
        .ReadData  (ReadData),
        .PCSrc     (PCSrc),
        .MemWrite  (MemWrite),
        .ALUResult (ALUResult),
        .WriteData (WriteData)
    );

    //////////////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////////////

    function automatic logic [31:0] lfsrNext(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // Taps 32 22 2 1
    endfunction

    function automatic logic [31:0] randBits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);
            r = {r[30:0], lfsrState[0]};
        end
        return r;
    endfunction

    function automatic logic [31:0] dpInstr(logic [3:0] cond, logic [3:0] op, logic s,
                                            logic [3:0] rd, logic [3:0] rn, logic i,
                                            logic [11:0] op2);
        return {cond, 2'b00, i, op, s, rn, rd, op2};
    endfunction

    function automatic logic [31:0] memInstr(logic [3:0] cond, logic load, logic up,
                                             logic [3:0] rd, logic [3:0] rn, logic [11:0] off);
        return {cond, 3'b010, 1'b1, up, 2'b00, load, rn, rd, off};  // Pre-indexed without writeback
    endfunction

    function automatic logic [31:0] brInstr(logic [3:0] cond, logic [23:0] off);
        return {cond, 4'b1010, off};
    endfunction

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    function automatic logic condHolds(logic [3:0] cond);
        logic r;
        case (cond[3:1])
            3'd0: r = modelFlags.z;
            3'd1: r = modelFlags.c;
            3'd2: r = modelFlags.n;
            3'd3: r = modelFlags.v;
            3'd4: r = modelFlags.c & ~modelFlags.z;
            3'd5: r = (modelFlags.n == modelFlags.v);
            3'd6: r = ~modelFlags.z & (modelFlags.n == modelFlags.v);
            default: r = 1'b1;
        endcase
        // Odd codes invert the even ones
        return (cond == 4'hF) ? 1'b0 : r ^ cond[0];
    endfunction

    function automatic logic [31:0] regValue(logic [3:0] idx);
        return (idx == 4'd15) ? PCPlus8 : modelRegs[idx];
    endfunction

    function automatic logic [31:0] rotImm(logic [3:0] rot, logic [7:0] imm);
        logic [31:0] r;
        r = {24'b0, imm};
        for (int i = 0; i < 2 * rot; i++) begin
            r = {r[0], r[31:1]};
        end
        return r;
    endfunction

    task automatic aluModel(input logic [3:0] op, input logic [31:0] a, input logic [31:0] b,
                            output logic [31:0] res, output flags_t f);
        logic [32:0] full;
        logic [31:0] x;
        logic [31:0] y;
        logic        borrow;
        f = modelFlags;  // C and V pass through for logic ops
        case (op)
            OpAnd, OpTst: res = a & b;
            OpEor, OpTeq: res = a ^ b;
            OpOrr:        res = a | b;
            OpMov:        res = b;
            OpBic:        res = a & ~b;
            OpMvn:        res = ~b;
            OpAdd, OpAdc, OpCmn: begin
                full = {1'b0, a} + {1'b0, b} + {32'b0, (op == OpAdc) & modelFlags.c};
                res  = full[31:0];
                f.c  = full[32];
                f.v  = (a[31] == b[31]) && (res[31] != a[31]);
            end
            default: begin
                x      = (op inside {OpRsb, OpRsc}) ? b : a;
                y      = (op inside {OpRsb, OpRsc}) ? a : b;
                borrow = (op inside {OpSbc, OpRsc}) ? ~modelFlags.c : 1'b0;
                full   = {1'b0, x} - {1'b0, y} - {32'b0, borrow};
                res    = full[31:0];
                f.c    = ~full[32];  // Carry means no borrow
                f.v    = (x[31] != y[31]) && (res[31] != x[31]);
            end
        endcase
        f.n = res[31];
        f.z = (res == 32'd0);
    endtask

    task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("ERR %s got %h expected %h", name, got, exp);
        end
    endtask

    // One instruction per cycle checked late in the cycle
    task automatic step(input logic [31:0] instr);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [3:0]  rd;
        logic        pass;
        logic        wr;
        logic        expMem;
        logic        expPc;
        flags_t      f;
        @(posedge clk);
        #10;
        Instr    = instr;
        PCPlus8  = PCPlus8 + 32'd4;
        ReadData = randBits(32);
        pass     = condHolds(instr[31:28]);
        rd       = instr[15:12];
        a        = regValue(instr[19:16]);
        f        = modelFlags;
        wr       = 1'b0;
        expMem   = 1'b0;
        expPc    = 1'b0;
        case (instr[27:26])
            2'b00: begin
                b = instr[25] ? rotImm(instr[11:8], instr[7:0]) : regValue(instr[3:0]);
                aluModel(instr[24:21], a, b, res, f);
                wr    = pass && (instr[24:23] != 2'b10);  // Compares write no Rd
                expPc = wr && (rd == 4'd15);
            end
            2'b01: begin
                res    = instr[23] ? a + {20'b0, instr[11:0]} : a - {20'b0, instr[11:0]};
                wr     = pass && instr[20];
                expMem = pass && !instr[20];
            end
            default: begin
                res   = PCPlus8 + {{6{instr[23]}}, instr[23:0], 2'b00};
                expPc = pass;
            end
        endcase
        #70;
        checkEq("ALUResult", ALUResult, res);
        checkEq("MemWrite", {31'b0, MemWrite}, {31'b0, expMem});
        checkEq("PCSrc", {31'b0, PCSrc}, {31'b0, expPc});
        if (instr[27:26] == 2'b01 && !instr[20]) begin
            checkEq("WriteData", WriteData, regValue(rd));
        end
        // Commit as the DUT does at the next edge
        if (wr && rd != 4'd15) begin
            modelRegs[rd] = (instr[27:26] == 2'b01) ? ReadData : res;
        end
        if (pass && instr[27:26] == 2'b00 && instr[20]) begin
            modelFlags.n = f.n;
            modelFlags.z = f.z;
            if (instr[24:21] inside {4'h2, 4'h3, 4'h4, 4'h5, 4'h6, 4'h7, 4'hA, 4'hB}) begin
                modelFlags.c = f.c;
                modelFlags.v = f.v;
            end
        end
    endtask

    //////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////

    task automatic resetTest();
        for (int r = 0; r < 15; r++) begin
            step(dpInstr(4'hE, OpMov, 1'b0, 4'(r), 4'd0, 1'b0, {8'h00, 4'(r)}));
        end
        step(memInstr(4'h0, 1'b0, 1'b1, 4'd1, 4'd2, 12'h010));  // EQ fails while Z is clear
        step(brInstr(4'h0, 24'h000040));
    endtask

    task automatic dataProcTest();
        logic [3:0] op;
        logic       s;
        logic       imm;
        for (int r = 0; r < 8; r++) begin
            step(dpInstr(4'hE, OpMov, 1'b0, 4'(r), 4'd0, 1'b1, 12'(randBits(12))));
        end
        for (int k = 0; k < 32; k++) begin
            op  = 4'(k % 16);
            s   = (op[3:2] == 2'b10) ? 1'b1 : 1'(randBits(1));
            imm = 1'(randBits(1));
            step(dpInstr(4'hE, op, s, 4'(randBits(3)), 4'(randBits(3)), imm,
                         imm ? 12'(randBits(12)) : 12'(randBits(3))));
        end
    endtask

    task automatic flagTest();
        logic [3:0] rn;
        logic [3:0] rm;
        logic [3:0] rd;
        for (int k = 0; k < 8; k++) begin
            rn = 4'(randBits(3));
            rm = randBits(1) ? rn : 4'(randBits(3));
            rd = 4'(randBits(3));
            step(dpInstr(4'hE, flagOps[k], 1'b1, rd, rn, 1'b0, {8'h00, rm}));
            step(dpInstr(4'hE, OpMov, 1'b0, rd, 4'd0, 1'b0, {8'h00, rd}));
            for (int c = 0; c < 15; c++) begin
                step(brInstr(4'(c), 24'(randBits(24))));
            end
            step(dpInstr(4'(randBits(4) % 15), OpMov, 1'b0, rd, 4'd0, 1'b1, 12'(randBits(12))));
            step(memInstr(4'(randBits(4) % 15), 1'b0, 1'b1, rd, rn, 12'(randBits(12))));
            step(dpInstr(4'hE, OpMov, 1'b0, rd, 4'd0, 1'b0, {8'h00, rd}));
        end
    endtask

    task automatic memTest();
        logic [3:0] rd;
        for (int k = 0; k < 4; k++) begin
            repeat (2) begin
                rd = 4'(randBits(3));
                step(memInstr(4'hE, k[1], k[0], rd, 4'(randBits(3)), 12'(randBits(12))));
                step(dpInstr(4'hE, OpMov, 1'b0, rd, 4'd0, 1'b0, {8'h00, rd}));
            end
        end
    endtask

    task automatic branchTest();
        step(brInstr(4'hE, 24'h000123));
        step(brInstr(4'hE, 24'hFFFF80));  // Backward
        step(brInstr(4'h0, 24'h000010));
        step(brInstr(4'h1, 24'h000010));  // One of EQ and NE fails
    endtask

    initial begin
        Instr      = 32'h0;
        PCPlus8    = 32'd8;
        ReadData   = 32'h0;
        modelFlags = '0;
        for (int i = 0; i < 15; i++) begin
            modelRegs[i] = '0;
        end
        while (rst !== 1'b0) @(posedge clk);
        resetTest();
        dataProcTest();
        flagTest();
        memTest();
        branchTest();
        @(posedge clk);
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > MaxCycles) begin
            $display("Timeout: tests still running after %0d cycles", cycles);
            $display("Errors: %0d", errors);
            $display("Finished with errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== files.f ====
common/cpuPkg.sv
decode/instrDecoder.sv
decode/condUnit.sv
design/alu.sv
design/regFile.sv
design/execCore.sv
dv/clockGen.sv
dv/execCoreTb.sv

// ==== Bender.yml ====
package:
  name: exec_core

sources:
  - common/cpuPkg.sv
  - decode/instrDecoder.sv
  - decode/condUnit.sv
  - design/alu.sv
  - design/regFile.sv
  - design/execCore.sv
  - target: simulation
    files:
      - dv/clockGen.sv
      - dv/execCoreTb.sv
